// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_eightbit
FILELIST   = verilog.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_eightbit.sv ====
`timescale 1ns/100ps

module tb_eightbit import cpu_pkg::*, bus_pkg::*;;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 5;
    localparam int WATCHDOG_CYCLES = 400 * 5;  // Transfers times cycles each.
    localparam int MODEL_STEPS     = 60;
    localparam int LOOP_REPEATS    = 4;
    localparam logic [ADDR_W-1:0] DATA_BASE = 8'h80;
    localparam logic [ADDR_W-1:0] LOOP_ADDR = 8'h32;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [ADDR_W-1:0]     paddr;
    logic [BUS_DATA_W-1:0] pwdata;
    logic [BUS_DATA_W-1:0] prdata;
    logic                  pready;

    logic [BUS_DATA_W-1:0] mem [256];
    logic [BUS_DATA_W-1:0] ref_mem [256];
    logic [ADDR_W-1:0]     fetch_q [$];
    logic [16:0]           data_q [$];  // Write flag, address, data.

    integer                seed;
    int                    wait_left;
    int                    apb_errors;
    int                    fetch_errors;
    int                    data_errors;
    int                    loop_hits;
    logic                  hi_seen;
    logic [ADDR_W-1:0]     hi_addr;
    logic                  rst_prev;
    logic                  setup_prev;
    logic                  hold_prev;
    logic                  wait_seen;
    logic [ADDR_W-1:0]     paddr_prev;
    logic                  pwrite_prev;
    logic [BUS_DATA_W-1:0] pwdata_prev;

    eightbit_top u_eightbit_top (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task show_mismatch(input string name, input logic [7:0] exp, input logic [7:0] act);
        $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
    endtask

    task put_inst(input logic [ADDR_W-1:0] addr, input logic [INST_W-1:0] word);
        mem[addr]        = word[15:8];  // High byte first.
        mem[addr + 8'd1] = word[7:0];
    endtask

    task load_program;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'hA5;
        end
        put_inst(8'h00, 16'h5180);  // lodi r1, 0x80
        put_inst(8'h02, 16'h5237);  // lodi r2, 0x37
        put_inst(8'h04, 16'h4215);  // addi r2, 0x15
        put_inst(8'h06, 16'h53c9);  // lodi r3, 0xc9
        put_inst(8'h08, 16'h3423);  // add r4, r2, r3
        put_inst(8'h0a, 16'h6523);  // nand r5, r2, r3
        put_inst(8'h0c, 16'h2210);  // str r2, [r1]
        put_inst(8'h0e, 16'h4101);
        put_inst(8'h10, 16'h2410);
        put_inst(8'h12, 16'h4101);
        put_inst(8'h14, 16'h2510);
        put_inst(8'h16, 16'h4101);
        put_inst(8'h18, 16'h2310);  // str r3, [r1]
        put_inst(8'h1a, 16'h1610);  // lod r6, [r1]
        put_inst(8'h1c, 16'h4101);
        put_inst(8'h1e, 16'h2610);  // str r6, [r1]
        put_inst(8'h20, 16'h5728);  // lodi r7, 0x28
        put_inst(8'h22, 16'h7700);  // jeqz r7, r0 taken.
        put_inst(8'h24, 16'h2510);  // Flushed store.
        put_inst(8'h26, 16'h2510);
        put_inst(8'h28, 16'h7720);  // jeqz r7, r2 not taken.
        put_inst(8'h2a, 16'h5830);
        put_inst(8'h2c, 16'h0800);  // jmp r8
        put_inst(8'h2e, 16'h2210);  // Flushed store.
        put_inst(8'h30, 16'h5932);
        put_inst(8'h32, 16'h0900);  // jmp r9, loops on itself.
        put_inst(8'h34, 16'h2210);  // Flushed store.
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = mem[i];
        end
    endtask

    // Instruction-level model. A taken branch also costs the fetch already in flight.
    task build_expected;
        logic [DATA_W-1:0]    rr [REG_COUNT];
        logic [ADDR_W-1:0]    rpc;
        logic [ADDR_W-1:0]    next_pc;
        logic [INST_W-1:0]    word;
        logic [REG_IDX_W-1:0] r0;
        logic [REG_IDX_W-1:0] r1;
        logic [REG_IDX_W-1:0] r2;
        logic [DATA_W-1:0]    imm;
        for (int i = 0; i < REG_COUNT; i++) begin
            rr[i] = '0;
        end
        rpc = '0;
        for (int step = 0; step < MODEL_STEPS; step++) begin
            word    = {ref_mem[rpc], ref_mem[rpc + 8'd1]};
            r0      = word[11:8];
            r1      = word[7:4];
            r2      = word[3:0];
            imm     = word[7:0];
            next_pc = rpc + 8'd2;
            fetch_q.push_back(rpc);
            case (opcode_t'(word[15:12]))
                op_jmp: begin
                    fetch_q.push_back(next_pc);
                    next_pc = rr[r0];
                end
                op_jeqz: begin
                    if (rr[r1] == '0) begin
                        fetch_q.push_back(next_pc);
                        next_pc = rr[r0];
                    end
                end
                op_lod: begin
                    data_q.push_back({1'b0, rr[r1], ref_mem[rr[r1]]});
                    rr[r0] = ref_mem[rr[r1]];
                end
                op_str: begin
                    data_q.push_back({1'b1, rr[r1], rr[r0]});
                    ref_mem[rr[r1]] = rr[r0];
                end
                op_add:  rr[r0] = rr[r1] + rr[r2];
                op_addi: rr[r0] = rr[r0] + imm;
                op_lodi: rr[r0] = imm;
                op_nand: rr[r0] = ~(rr[r1] & rr[r2]);
                default: ;
            endcase
            rpc = next_pc;
        end
    endtask

    task check_protocol;
        if (rst_prev && !rst) begin
            assert (!psel) else begin
                apb_errors++;
                show_mismatch("psel", 8'd0, 8'(psel));
            end
            assert (!penable) else begin
                apb_errors++;
                show_mismatch("penable", 8'd0, 8'(penable));
            end
        end
        if (setup_prev) begin
            assert (psel && penable) else begin
                apb_errors++;
                show_mismatch("penable", 8'd1, 8'(penable));
            end
        end
        if (hold_prev) begin
            assert (paddr == paddr_prev) else begin
                apb_errors++;
                show_mismatch("paddr", paddr_prev, paddr);
            end
            assert (pwrite == pwrite_prev) else begin
                apb_errors++;
                show_mismatch("pwrite", 8'(pwrite_prev), 8'(pwrite));
            end
            assert (pwdata == pwdata_prev) else begin
                apb_errors++;
                show_mismatch("pwdata", pwdata_prev, pwdata);
            end
        end
        rst_prev    = rst;
        setup_prev  = !rst && psel && !penable;
        hold_prev   = !rst && psel && !(penable && pready);
        wait_seen   = !rst && psel && penable && !pready;
        paddr_prev  = paddr;
        pwrite_prev = pwrite;
        pwdata_prev = pwdata;
    endtask

    task check_fetch;
        logic [ADDR_W-1:0] exp;
        if (!paddr[0]) begin
            if (hi_seen) begin
                fetch_errors++;
                $display("Fetch at %h began before the previous pair was finished", paddr);
            end
            if (fetch_q.size() == 0) begin
                fetch_errors++;
                $display("Fetch at %h lies past the expected instruction stream", paddr);
            end else begin
                exp = fetch_q.pop_front();
                assert (paddr == exp) else begin
                    fetch_errors++;
                    show_mismatch("paddr", exp, paddr);
                end
            end
            hi_seen = 1'b1;
            hi_addr = paddr;
            if (paddr == LOOP_ADDR) begin
                loop_hits++;
            end
        end else begin
            assert (hi_seen && paddr == hi_addr + 8'd1) else begin
                fetch_errors++;
                show_mismatch("paddr", hi_addr + 8'd1, paddr);
            end
            hi_seen = 1'b0;
        end
    endtask

    task check_data;
        logic [16:0] exp;
        if (data_q.size() == 0) begin
            data_errors++;
            $display("Data transfer at time %0t to address %h was not expected", $time, paddr);
        end else begin
            exp = data_q.pop_front();
            assert (pwrite == exp[16]) else begin
                data_errors++;
                show_mismatch("pwrite", 8'(exp[16]), 8'(pwrite));
            end
            assert (paddr == exp[15:8]) else begin
                data_errors++;
                show_mismatch("paddr", exp[15:8], paddr);
            end
            if (pwrite) begin
                assert (pwdata == exp[7:0]) else begin
                    data_errors++;
                    show_mismatch("pwdata", exp[7:0], pwdata);
                end
            end
        end
    endtask

    task complete_transfer;
        if (psel && penable && pready) begin
            if (pwrite) begin
                mem[paddr] = pwdata;
                check_data();
            end else if (paddr < DATA_BASE) begin
                check_fetch();
            end else begin
                check_data();
            end
        end
    endtask

    task drive_slave;
        if (setup_prev) begin
            wait_left = $random(seed) & 3;  // Zero to three wait states.
            pready    = (wait_left == 0);
        end else if (wait_seen) begin
            wait_left--;
            pready = (wait_left == 0);
        end else begin
            pready = 1'b0;
        end
        prdata = mem[paddr];
    endtask

    // Memory model samples mid-cycle and answers just after the rising edge.
    always begin
        @(negedge clk);
        check_protocol();
        complete_transfer();
        @(posedge clk);
        #2;
        drive_slave();
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        pready       = 1'b0;
        prdata       = '0;
        seed         = 32'h89c0dbd0;
        wait_left    = 0;
        apb_errors   = 0;
        fetch_errors = 0;
        data_errors  = 0;
        loop_hits    = 0;
        hi_seen      = 1'b0;
        hi_addr      = '0;
        rst_prev     = 1'b1;
        setup_prev   = 1'b0;
        hold_prev    = 1'b0;
        wait_seen    = 1'b0;
        paddr_prev   = '0;
        pwrite_prev  = 1'b0;
        pwdata_prev  = '0;
        load_program();
        build_expected();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        wait (loop_hits == LOOP_REPEATS);
        assert (data_q.size() == 0) else begin
            data_errors++;
            $display("%0d expected data transfers never reached the bus", data_q.size());
        end
        $display("Errors: apb=%0d fetch=%0d data=%0d", apb_errors, fetch_errors, data_errors);
        if (apb_errors + fetch_errors + data_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the program did not reach its final loop %0d times", LOOP_REPEATS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== source/apb_arbiter.sv ====
`timescale 1ns/100ps

module apb_arbiter import bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    mem_req_if.arbiter            fetch_bus,
    mem_req_if.arbiter            data_bus,
    output logic                  psel,
    output logic                  penable,
    output logic                  pwrite,
    output logic [ADDR_W-1:0]     paddr,
    output logic [BUS_DATA_W-1:0] pwdata,
    input  logic [BUS_DATA_W-1:0] prdata,
    input  logic                  pready
);

    apb_phase_t phase;
    logic       owner_data;  // Set when execute owns the transfer.

    assign psel    = (phase != apb_idle);
    assign penable = (phase == apb_access);

    assign fetch_bus.ready = penable && pready && !owner_data;
    assign data_bus.ready  = penable && pready && owner_data;
    assign fetch_bus.rdata = prdata;
    assign data_bus.rdata  = prdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase      <= apb_idle;
            owner_data <= 1'b0;
            pwrite     <= 1'b0;
        end else begin
            case (phase)
                apb_idle: begin
                    if (data_bus.req) begin  // Data access has priority.
                        owner_data <= 1'b1;
                        pwrite     <= data_bus.we;
                        phase      <= apb_setup;
                    end else if (fetch_bus.req) begin
                        owner_data <= 1'b0;
                        pwrite     <= fetch_bus.we;
                        phase      <= apb_setup;
                    end
                end
                apb_setup: phase <= apb_access;
                default: begin
                    if (pready) begin
                        phase  <= apb_idle;
                        pwrite <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == apb_idle) begin
            paddr  <= data_bus.req ? data_bus.addr : fetch_bus.addr;
            pwdata <= data_bus.req ? data_bus.wdata : fetch_bus.wdata;
        end
    end

endmodule

// ==== source/bus_pkg.sv ====
package bus_pkg;

    localparam int ADDR_W     = 8;
    localparam int BUS_DATA_W = 8;

    typedef enum logic [1:0] {
        apb_idle,
        apb_setup,
        apb_access
    } apb_phase_t;

endpackage

// ==== source/core_seq.sv ====
`timescale 1ns/100ps

module core_seq import cpu_pkg::*, bus_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 fetch_start,
    input  logic                 fetch_done,
    input  logic [INST_W-1:0]    inst,
    output logic [INST_W-1:0]    dec_inst,
    input  opcode_t              op,
    input  logic [REG_IDX_W-1:0] reg0,
    input  logic [REG_IDX_W-1:0] reg1,
    input  logic [REG_IDX_W-1:0] reg2,
    input  logic [DATA_W-1:0]    imm,
    input  logic                 src_a_sel,
    input  logic                 src_b_sel,
    output logic [REG_IDX_W-1:0] rd_a_idx,
    output logic [REG_IDX_W-1:0] rd_b_idx,
    input  logic [DATA_W-1:0]    rd_a,
    input  logic [DATA_W-1:0]    rd_b,
    output logic                 exec_start,
    output opcode_t              exec_op,
    output logic [DATA_W-1:0]    exec_a,
    output logic [DATA_W-1:0]    exec_b,
    output logic [DATA_W-1:0]    exec_imm,
    output logic [REG_IDX_W-1:0] exec_dst,
    input  logic                 exec_done,
    input  logic                 branch_taken,
    input  logic [ADDR_W-1:0]    branch_target,
    output logic [ADDR_W-1:0]    pc
);

    typedef enum logic [1:0] {fs_empty, fs_busy, fs_drop, fs_full} fetch_slot_t;
    typedef enum logic {xs_idle, xs_busy} exec_slot_t;

    fetch_slot_t fetch_state;
    exec_slot_t  exec_state;
    logic [INST_W-1:0] inst_q;
    logic taken;
    logic issue;

    assign taken    = exec_done && branch_taken;
    assign issue    = (fetch_state == fs_full) && (exec_state == xs_idle);
    assign dec_inst = inst_q;
    assign rd_a_idx = src_a_sel ? reg0 : reg1;
    assign rd_b_idx = src_b_sel ? reg1 : reg2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_state <= fs_empty;
            exec_state  <= xs_idle;
            fetch_start <= 1'b0;
            exec_start  <= 1'b0;
            pc          <= '0;
        end else begin
            fetch_start <= 1'b0;
            exec_start  <= 1'b0;
            case (fetch_state)
                fs_empty: begin
                    if (!taken) begin  // Wait for the new pc.
                        fetch_start <= 1'b1;
                        fetch_state <= fs_busy;
                    end
                end
                fs_busy: begin
                    if (fetch_done) begin
                        fetch_state <= taken ? fs_empty : fs_full;
                    end else if (taken) begin
                        fetch_state <= fs_drop;
                    end
                end
                fs_drop: begin
                    if (fetch_done) begin
                        fetch_state <= fs_empty;  // Stale bytes discarded.
                    end
                end
                default: begin
                    if (taken) begin
                        fetch_state <= fs_empty;
                    end else if (issue) begin
                        fetch_start <= 1'b1;
                        fetch_state <= fs_busy;
                    end
                end
            endcase
            case (exec_state)
                xs_idle: begin
                    if (issue) begin
                        exec_start <= 1'b1;
                        exec_state <= xs_busy;
                        pc         <= pc + ADDR_W'(2);
                    end
                end
                default: begin
                    if (exec_done) begin
                        exec_state <= xs_idle;
                        if (branch_taken) begin
                            pc <= branch_target;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            inst_q <= inst;
        end
        if (issue) begin
            exec_op  <= op;
            exec_a   <= rd_a;
            exec_b   <= rd_b;
            exec_imm <= imm;
            exec_dst <= reg0;  // Every write targets reg0.
        end
    end

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    localparam int DATA_W    = 8;
    localparam int INST_W    = 16;
    localparam int OPCODE_W  = 4;
    localparam int REG_COUNT = 16;
    localparam int REG_IDX_W = 4;

    // Field positions inside a 16-bit instruction.
    localparam int OP_MSB    = 15;
    localparam int REG0_MSB  = 11;
    localparam int REG1_MSB  = 7;
    localparam int REG2_MSB  = 3;

    typedef enum logic [OPCODE_W-1:0] {
        op_jmp  = 4'd0,
        op_lod  = 4'd1,
        op_str  = 4'd2,
        op_add  = 4'd3,
        op_addi = 4'd4,
        op_lodi = 4'd5,
        op_nand = 4'd6,
        op_jeqz = 4'd7
    } opcode_t;

endpackage

// ==== source/decode_unit.sv ====
`timescale 1ns/100ps

module decode_unit import cpu_pkg::*; (
    input  logic [INST_W-1:0]    inst,
    output opcode_t              op,
    output logic [REG_IDX_W-1:0] reg0,
    output logic [REG_IDX_W-1:0] reg1,
    output logic [REG_IDX_W-1:0] reg2,
    output logic [DATA_W-1:0]    imm,
    output logic                 src_a_sel,
    output logic                 src_b_sel
);

    assign op   = opcode_t'(inst[OP_MSB -: OPCODE_W]);
    assign reg0 = inst[REG0_MSB -: REG_IDX_W];
    assign reg1 = inst[REG1_MSB -: REG_IDX_W];
    assign reg2 = inst[REG2_MSB -: REG_IDX_W];
    assign imm  = inst[DATA_W-1:0];

    // Port a takes reg0 when set, else reg1. Port b takes reg1 when set, else reg2.
    always_comb begin
        case (op)
            op_str, op_jmp, op_jeqz: begin
                src_a_sel = 1'b1;
                src_b_sel = 1'b1;
            end
            op_addi: begin
                src_a_sel = 1'b1;
                src_b_sel = 1'b0;
            end
            default: begin
                src_a_sel = 1'b0;
                src_b_sel = 1'b0;
            end
        endcase
    end

endmodule

// ==== source/eightbit_top.sv ====
`timescale 1ns/100ps

module eightbit_top import cpu_pkg::*, bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    output logic                  psel,
    output logic                  penable,
    output logic                  pwrite,
    output logic [ADDR_W-1:0]     paddr,
    output logic [BUS_DATA_W-1:0] pwdata,
    input  logic [BUS_DATA_W-1:0] prdata,
    input  logic                  pready
);

    logic                 fetch_start;
    logic                 fetch_done;
    logic [INST_W-1:0]    inst;
    logic [INST_W-1:0]    dec_inst;
    opcode_t              op;
    logic [REG_IDX_W-1:0] reg0;
    logic [REG_IDX_W-1:0] reg1;
    logic [REG_IDX_W-1:0] reg2;
    logic [DATA_W-1:0]    imm;
    logic                 src_a_sel;
    logic                 src_b_sel;
    logic [REG_IDX_W-1:0] rd_a_idx;
    logic [REG_IDX_W-1:0] rd_b_idx;
    logic [DATA_W-1:0]    rd_a;
    logic [DATA_W-1:0]    rd_b;
    logic                 exec_start;
    opcode_t              exec_op;
    logic [DATA_W-1:0]    exec_a;
    logic [DATA_W-1:0]    exec_b;
    logic [DATA_W-1:0]    exec_imm;
    logic [REG_IDX_W-1:0] exec_dst;
    logic                 exec_done;
    logic [DATA_W-1:0]    result;
    logic                 wr_en;
    logic                 branch_taken;
    logic [ADDR_W-1:0]    branch_target;
    logic [ADDR_W-1:0]    pc;

    mem_req_if fetch_bus ();
    mem_req_if data_bus ();

    core_seq u_core_seq (
        .clk           (clk),
        .rst           (rst),
        .fetch_start   (fetch_start),
        .fetch_done    (fetch_done),
        .inst          (inst),
        .dec_inst      (dec_inst),
        .op            (op),
        .reg0          (reg0),
        .reg1          (reg1),
        .reg2          (reg2),
        .imm           (imm),
        .src_a_sel     (src_a_sel),
        .src_b_sel     (src_b_sel),
        .rd_a_idx      (rd_a_idx),
        .rd_b_idx      (rd_b_idx),
        .rd_a          (rd_a),
        .rd_b          (rd_b),
        .exec_start    (exec_start),
        .exec_op       (exec_op),
        .exec_a        (exec_a),
        .exec_b        (exec_b),
        .exec_imm      (exec_imm),
        .exec_dst      (exec_dst),
        .exec_done     (exec_done),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc)
    );

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst         (rst),
        .fetch_start (fetch_start),
        .pc          (pc),
        .fetch_done  (fetch_done),
        .inst        (inst),
        .bus         (fetch_bus.requester)
    );

    decode_unit u_decode_unit (
        .inst      (dec_inst),
        .op        (op),
        .reg0      (reg0),
        .reg1      (reg1),
        .reg2      (reg2),
        .imm       (imm),
        .src_a_sel (src_a_sel),
        .src_b_sel (src_b_sel)
    );

    exec_unit u_exec_unit (
        .clk           (clk),
        .rst           (rst),
        .exec_start    (exec_start),
        .op            (exec_op),
        .a             (exec_a),
        .b             (exec_b),
        .imm           (exec_imm),
        .exec_done     (exec_done),
        .result        (result),
        .wr_en         (wr_en),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .bus           (data_bus.requester)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rd_a_idx (rd_a_idx),
        .rd_b_idx (rd_b_idx),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .wr_en    (wr_en),
        .wr_idx   (exec_dst),
        .wr_data  (result)
    );

    apb_arbiter u_apb_arbiter (
        .clk       (clk),
        .rst       (rst),
        .fetch_bus (fetch_bus.arbiter),
        .data_bus  (data_bus.arbiter),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready)
    );

endmodule

// ==== source/exec_unit.sv ====
`timescale 1ns/100ps

module exec_unit import cpu_pkg::*, bus_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              exec_start,
    input  opcode_t           op,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    input  logic [DATA_W-1:0] imm,
    output logic              exec_done,
    output logic [DATA_W-1:0] result,
    output logic              wr_en,
    output logic              branch_taken,
    output logic [ADDR_W-1:0] branch_target,
    mem_req_if.requester      bus
);

    typedef enum logic {ex_idle, ex_mem} exec_phase_t;

    exec_phase_t state;
    logic        is_mem;
    logic        is_branch;

    assign is_mem    = (op == op_lod) || (op == op_str);
    assign is_branch = (op == op_jmp) || (op == op_jeqz);

    // Store writes a to address b. Load reads address a.
    assign bus.req   = (state == ex_mem);
    assign bus.we    = (op == op_str);
    assign bus.addr  = (op == op_str) ? b : a;
    assign bus.wdata = a;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ex_idle;
            exec_done    <= 1'b0;
            wr_en        <= 1'b0;
            branch_taken <= 1'b0;
        end else begin
            exec_done    <= 1'b0;
            wr_en        <= 1'b0;
            branch_taken <= 1'b0;
            case (state)
                ex_idle: begin
                    if (exec_start && is_mem) begin
                        state <= ex_mem;
                    end else if (exec_start) begin
                        exec_done    <= 1'b1;
                        wr_en        <= !is_branch;
                        branch_taken <= (op == op_jmp) || (op == op_jeqz && b == '0);
                    end
                end
                default: begin
                    if (bus.ready) begin
                        state     <= ex_idle;
                        exec_done <= 1'b1;
                        wr_en     <= (op == op_lod);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (exec_start) begin
            branch_target <= a;
            case (op)
                op_add:  result <= a + b;
                op_addi: result <= a + imm;
                op_lodi: result <= imm;
                op_nand: result <= ~(a & b);
                default: result <= result;
            endcase
        end else if (state == ex_mem && bus.ready) begin
            result <= bus.rdata;  // Load data.
        end
    end

endmodule

// ==== source/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit import cpu_pkg::*, bus_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_start,
    input  logic [ADDR_W-1:0] pc,
    output logic              fetch_done,
    output logic [INST_W-1:0] inst,
    mem_req_if.requester      bus
);

    typedef enum logic [1:0] {f_idle, f_hi, f_lo} fetch_phase_t;

    fetch_phase_t          state;
    logic [ADDR_W-1:0]     addr_q;
    logic [BUS_DATA_W-1:0] hi_q;

    assign bus.req   = (state != f_idle);
    assign bus.we    = 1'b0;
    assign bus.addr  = addr_q;
    assign bus.wdata = '0;

    assign fetch_done = (state == f_lo) && bus.ready;
    assign inst       = {hi_q, bus.rdata};  // Big-endian, high byte first.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= f_idle;
        end else begin
            case (state)
                f_idle: if (fetch_start) state <= f_hi;
                f_hi:   if (bus.ready) state <= f_lo;
                default: if (bus.ready) state <= f_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == f_idle && fetch_start) begin
            addr_q <= pc;
        end else if (state == f_hi && bus.ready) begin
            addr_q <= addr_q + 1'b1;
            hi_q   <= bus.rdata;
        end
    end

endmodule

// ==== source/mem_req_if.sv ====
`timescale 1ns/100ps

interface mem_req_if import bus_pkg::*; ();

    logic                  req;
    logic                  we;
    logic [ADDR_W-1:0]     addr;
    logic [BUS_DATA_W-1:0] wdata;
    logic [BUS_DATA_W-1:0] rdata;
    logic                  ready;  // One-cycle completion pulse.

    modport requester (
        output req, we, addr, wdata,
        input  rdata, ready
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, ready
    );

endinterface

// ==== source/reg_file.sv ====
`timescale 1ns/100ps

module reg_file import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [REG_IDX_W-1:0] rd_a_idx,
    input  logic [REG_IDX_W-1:0] rd_b_idx,
    output logic [DATA_W-1:0]    rd_a,
    output logic [DATA_W-1:0]    rd_b,
    input  logic                 wr_en,
    input  logic [REG_IDX_W-1:0] wr_idx,
    input  logic [DATA_W-1:0]    wr_data
);

    logic [DATA_W-1:0] regs [REG_COUNT];

    assign rd_a = regs[rd_a_idx];
    assign rd_b = regs[rd_b_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;  // All registers start at zero.
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

// ==== verilog.f ====
source/cpu_pkg.sv
source/bus_pkg.sv
source/mem_req_if.sv
source/reg_file.sv
source/decode_unit.sv
source/fetch_unit.sv
source/exec_unit.sv
source/core_seq.sv
source/apb_arbiter.sv
source/eightbit_top.sv
sim/tb_eightbit.sv
